// ==== logic/stream_source_config.svh ====
`ifndef STREAM_SOURCE_CONFIG_SVH
`define STREAM_SOURCE_CONFIG_SVH

// stream and memory word width
`define SRC_DATA_WIDTH 32

// word address into the bank, 1024 words
`define SRC_ADDR_WIDTH 10

// line length and line count fields
`define SRC_CNT_WIDTH 8

// address fifo entries, power of two
`define SRC_FIFO_DEPTH 2

`define SRC_CREDITS 4 // beats the consumer can buffer

`endif

// ==== logic/stream_source_pkg.sv ====
`include "stream_source_config.svh"

package stream_source_pkg;

  // one data word on the stream and in the bank
  typedef logic [`SRC_DATA_WIDTH-1:0] stream_word_t;

  // word address, wraps at the bank size
  typedef logic [`SRC_ADDR_WIDTH-1:0] mem_addr_t;

  typedef logic [`SRC_CNT_WIDTH-1:0] job_cnt_t; // line length or line count

  // controller states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DONE    = 2'd2
  } streamer_state_t;

endpackage

// ==== logic/addr_fifo.sv ====
`include "stream_source_config.svh"

module addr_fifo
  import stream_source_pkg::*;
#(
  parameter int unsigned DEPTH = `SRC_FIFO_DEPTH // power of two, at least 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      push_i,
  input  mem_addr_t data_i,
  input  logic      pop_i,
  output mem_addr_t data_o,
  output logic      empty_o,
  output logic      full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mem_addr_t        buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign data_o  = buf_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of two
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) buf_q[wr_ptr_q] <= data_i;
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && !clear_i |-> !full_o || pop_i);

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i && !clear_i |-> !empty_o);

endmodule

// ==== logic/stream_addrgen.sv ====
`include "stream_source_config.svh"

module stream_addrgen
  import stream_source_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      enable_i,
  input  logic      start_i,
  input  mem_addr_t base_i,
  input  mem_addr_t word_stride_i,
  input  mem_addr_t line_stride_i,
  input  job_cnt_t  line_len_i,
  input  job_cnt_t  line_cnt_i,
  input  logic      full_i,
  output logic      addr_valid_o,
  output mem_addr_t addr_o,
  output logic      done_o
);

  // job parameters held for the whole walk
  mem_addr_t word_stride_q;
  mem_addr_t line_stride_q;
  job_cnt_t  line_len_q;
  job_cnt_t  line_cnt_q;

  mem_addr_t line_base_q; // first address of the current line
  mem_addr_t cur_addr_q;

  job_cnt_t  word_idx_q;
  job_cnt_t  line_idx_q;
  logic      active_q;    // job loaded and addresses left
  logic      done_q;

  logic      push;
  logic      last_word;
  logic      last_line;

  // one address per cycle when the fifo can take it
  assign push      = active_q & enable_i & ~full_i;
  assign last_word = (word_idx_q == line_len_q - 1'b1);
  assign last_line = (line_idx_q == line_cnt_q - 1'b1);

  assign addr_valid_o = push;
  assign addr_o       = cur_addr_q;
  assign done_o       = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (start_i) begin
      active_q   <= 1'b1;
      done_q     <= 1'b0;
      word_idx_q <= '0;
      line_idx_q <= '0;
    end else if (push) begin
      if (!last_word) begin
        word_idx_q <= word_idx_q + 1'b1;
      end else if (!last_line) begin
        word_idx_q <= '0;
        line_idx_q <= line_idx_q + 1'b1;
      end else begin
        active_q <= 1'b0; // final address goes out this cycle
        done_q   <= 1'b1;
      end
    end
  end

  // addresses built with adds only, wrapping at the bank size
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      word_stride_q <= word_stride_i;
      line_stride_q <= line_stride_i;
      line_len_q    <= line_len_i;
      line_cnt_q    <= line_cnt_i;
      line_base_q   <= base_i;
      cur_addr_q    <= base_i;
    end else if (push) begin
      if (!last_word) begin
        cur_addr_q <= cur_addr_q + word_stride_q;
      end else begin
        line_base_q <= line_base_q + line_stride_q;
        cur_addr_q  <= line_base_q + line_stride_q;
      end
    end
  end

endmodule

// ==== logic/stream_source.sv ====
`include "stream_source_config.svh"

module stream_source
  import stream_source_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  mem_addr_t    base_i,
  input  mem_addr_t    word_stride_i,
  input  mem_addr_t    line_stride_i,
  input  job_cnt_t     line_len_i,
  input  job_cnt_t     line_cnt_i,
  input  logic         credit_i,
  input  logic         mem_rvalid_i,
  input  stream_word_t mem_rdata_i,
  output logic         ready_start_o,
  output logic         done_o,
  output logic         mem_req_o,
  output mem_addr_t    mem_raddr_o,
  output logic         stream_valid_o,
  output stream_word_t stream_data_o
);

  localparam int unsigned CRED_W = $clog2(`SRC_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`SRC_CREDITS);

  streamer_state_t state_q, state_d;

  logic             gen_enable;
  logic             gen_clear;
  logic             gen_done;
  logic             addr_valid;
  mem_addr_t        addr;
  mem_addr_t        fifo_addr;
  logic             fifo_empty;
  logic             fifo_full;
  logic [CRED_W-1:0] credit_q;

  stream_addrgen i_addrgen (
    .clk_i         ( clk_i                   ),
    .rst_ni        ( rst_ni                  ),
    .clear_i       ( gen_clear               ),
    .enable_i      ( gen_enable              ),
    .start_i       ( start_i & ready_start_o ),
    .base_i        ( base_i                  ),
    .word_stride_i ( word_stride_i           ),
    .line_stride_i ( line_stride_i           ),
    .line_len_i    ( line_len_i              ),
    .line_cnt_i    ( line_cnt_i              ),
    .full_i        ( fifo_full               ),
    .addr_valid_o  ( addr_valid              ),
    .addr_o        ( addr                    ),
    .done_o        ( gen_done                )
  );

  addr_fifo #(
    .DEPTH ( `SRC_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( clear_i    ),
    .push_i  ( addr_valid ),
    .data_i  ( addr       ),
    .pop_i   ( mem_req_o  ),
    .data_o  ( fifo_addr  ),
    .empty_o ( fifo_empty ),
    .full_o  ( fifo_full  )
  );

  // a read only goes out with a credit in hand, so the beat never waits
  assign mem_req_o      = (state_q != IDLE) & ~fifo_empty & (credit_q != '0);
  assign mem_raddr_o    = fifo_addr;
  assign stream_valid_o = mem_rvalid_i;
  assign stream_data_o  = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CRED_MAX;
    end else if (clear_i) begin
      credit_q <= CRED_MAX;
    end else if (mem_req_o && !credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (credit_i && !mem_req_o) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= IDLE;
    else if (clear_i) state_q <= IDLE;
    else state_q <= state_d;
  end

  always_comb begin
    state_d       = state_q;
    done_o        = 1'b0;
    ready_start_o = 1'b0;
    gen_enable    = 1'b0;
    gen_clear     = clear_i;
    case (state_q)
      IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) state_d = WORKING;
      end
      WORKING: begin
        gen_enable = 1'b1;
        if (gen_done) state_d = DONE;
      end
      DONE: begin
        // last address already left the generator, wait for the fifo to drain
        if (fifo_empty) begin
          state_d   = IDLE;
          done_o    = 1'b1;
          gen_clear = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  a_beat_follows_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_valid_o == $past(mem_req_o));

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CRED_MAX);

  a_start_in_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> state_q == IDLE);

endmodule

// ==== logic/tcdm_bank.sv ====
`include "stream_source_config.svh"

module tcdm_bank
  import stream_source_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  mem_addr_t    raddr_i,
  input  logic         we_i,
  input  mem_addr_t    waddr_i,
  input  stream_word_t wdata_i,
  output logic         rvalid_o,
  output stream_word_t rdata_o
);

  localparam int unsigned WORDS = 1 << `SRC_ADDR_WIDTH;

  stream_word_t mem_q [WORDS];
  stream_word_t rdata_q;
  logic         rvalid_q;

  // same-word write and read in one cycle returns the old word
  always_ff @(posedge clk_i) begin
    if (we_i) mem_q[waddr_i] <= wdata_i;
    if (req_i) rdata_q <= mem_q[raddr_i];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i; // response one cycle after each request
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== logic/stream_source_top.sv ====
`include "stream_source_config.svh"

module stream_source_top
  import stream_source_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  mem_addr_t    base_i,
  input  mem_addr_t    word_stride_i,
  input  mem_addr_t    line_stride_i,
  input  job_cnt_t     line_len_i,
  input  job_cnt_t     line_cnt_i,
  input  logic         credit_i,
  input  logic         mem_we_i,    // preload, only while idle
  input  mem_addr_t    mem_waddr_i,
  input  stream_word_t mem_wdata_i,
  output logic         ready_start_o,
  output logic         done_o,
  output logic         stream_valid_o,
  output stream_word_t stream_data_o
);

  logic         mem_req;
  mem_addr_t    mem_raddr;
  logic         mem_rvalid;
  stream_word_t mem_rdata;

  stream_source i_source (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .base_i         ( base_i         ),
    .word_stride_i  ( word_stride_i  ),
    .line_stride_i  ( line_stride_i  ),
    .line_len_i     ( line_len_i     ),
    .line_cnt_i     ( line_cnt_i     ),
    .credit_i       ( credit_i       ),
    .mem_rvalid_i   ( mem_rvalid     ),
    .mem_rdata_i    ( mem_rdata      ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .mem_req_o      ( mem_req        ),
    .mem_raddr_o    ( mem_raddr      ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  )
  );

  tcdm_bank i_bank (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .req_i    ( mem_req     ),
    .raddr_i  ( mem_raddr   ),
    .we_i     ( mem_we_i    ),
    .waddr_i  ( mem_waddr_i ),
    .wdata_i  ( mem_wdata_i ),
    .rvalid_o ( mem_rvalid  ),
    .rdata_o  ( mem_rdata   )
  );

endmodule

// ==== tests/tb_stream_source.sv ====
`include "stream_source_config.svh"

module tb_stream_source
  import stream_source_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_JOBS = 12;
  localparam int ALL_JOBS = NUM_JOBS + 2; // random jobs, then a cleared job and a stalled job
  localparam int DELAY_N  = 64;
  localparam int WORDS    = 1 << `SRC_ADDR_WIDTH;

  logic         clk_i = 1'b0;
  logic         rst_ni, clear_i, start_i, credit_i, mem_we_i;
  mem_addr_t    base_i, word_stride_i, line_stride_i, mem_waddr_i;
  job_cnt_t     line_len_i, line_cnt_i;
  stream_word_t mem_wdata_i;
  logic         ready_start_o, done_o, stream_valid_o;
  stream_word_t stream_data_o;

  integer       seed;
  stream_word_t model_mem [WORDS];
  stream_word_t exp_q [$];   // data still owed by the running job
  int           due_q [$];   // cycle at which each held beat is handed back
  int           delay_tab [DELAY_N];
  mem_addr_t    job_base [ALL_JOBS];
  mem_addr_t    job_wstride [ALL_JOBS];
  mem_addr_t    job_lstride [ALL_JOBS];
  job_cnt_t     job_len [ALL_JOBS];
  job_cnt_t     job_cnt [ALL_JOBS];
  int           cycle, beats, done_count, watch_cycles;
  int           outstanding; // beats received and not yet credited
  logic         hold_credits, flush_pending;

  stream_source_top dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic check_word(input stream_word_t got, input stream_word_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // word address of one beat, straight from the two-dimensional rule
  function automatic mem_addr_t expected_addr(input int j, input int l, input int w);
    return mem_addr_t'(int'(job_base[j]) + l * int'(job_lstride[j]) + w * int'(job_wstride[j]));
  endfunction

  // one clock step, the consumer looks at the stream on the falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    cycle++;
    if (flush_pending) begin
      // consumer is flushed with the source, a read issued with the clear may land here
      exp_q.delete();
      due_q.delete();
      outstanding   = 0;
      flush_pending = 1'b0;
      credit_i      = 1'b0;
    end else begin
      if (stream_valid_o) begin
        check_flag(exp_q.size() != 0, 1'b1, "beat only while data is owed");
        check_word(stream_data_o, exp_q.pop_front(), "stream data");
        due_q.push_back(cycle + delay_tab[beats % DELAY_N]);
        beats++;
        outstanding++;
        check_flag(outstanding <= `SRC_CREDITS, 1'b1, "beats held within credit limit");
      end
      if (done_o) begin
        check_flag(exp_q.size() == 0, 1'b1, "all beats out by done");
        done_count++;
      end
      if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        outstanding--;
        credit_i = 1'b1;
      end else begin
        credit_i = 1'b0;
      end
    end
  endtask

  task automatic preload_bank();
    for (int a = 0; a < WORDS; a++) begin
      model_mem[a] = stream_word_t'($random(seed));
      mem_we_i     = 1'b1;
      mem_waddr_i  = mem_addr_t'(a);
      mem_wdata_i  = model_mem[a];
      next_cycle();
    end
    mem_we_i = 1'b0;
  endtask

  // called right after a falling edge
  task automatic start_job(input int j);
    check_flag(ready_start_o, 1'b1, "ready_start_o before start");
    for (int l = 0; l < int'(job_cnt[j]); l++) begin
      for (int w = 0; w < int'(job_len[j]); w++) begin
        exp_q.push_back(model_mem[expected_addr(j, l, w)]);
      end
    end
    base_i        = job_base[j];
    word_stride_i = job_wstride[j];
    line_stride_i = job_lstride[j];
    line_len_i    = job_len[j];
    line_cnt_i    = job_cnt[j];
    start_i       = 1'b1;
    next_cycle();
    start_i = 1'b0;
  endtask

  task automatic wait_done();
    do begin
      next_cycle();
    end while (done_o !== 1'b1);
    next_cycle();
    check_flag(ready_start_o, 1'b1, "ready_start_o after done");
  endtask

  initial begin : watchdog
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk_i);
    $display("Timeout: the jobs did not finish within %0d cycles", watch_cycles);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int   words;
    int   snap;
    logic ready_seen;
    seed = 32'h89cc_6263;
    {rst_ni, clear_i, start_i, credit_i, mem_we_i} = '0;
    {base_i, word_stride_i, line_stride_i, mem_waddr_i} = '0;
    {line_len_i, line_cnt_i, mem_wdata_i} = '0;
    {cycle, beats, outstanding, done_count, watch_cycles} = '0;
    hold_credits  = 1'b0;
    flush_pending = 1'b0;
    words         = 0;
    for (int j = 0; j < ALL_JOBS; j++) begin
      job_base[j]    = mem_addr_t'($random(seed));
      job_wstride[j] = mem_addr_t'($random(seed));
      job_lstride[j] = mem_addr_t'($random(seed));
      job_len[j]     = job_cnt_t'(1 + $unsigned($random(seed)) % 8);
      job_cnt[j]     = job_cnt_t'(1 + $unsigned($random(seed)) % 8);
      if (j >= NUM_JOBS) begin
        job_len[j] = 8; // long enough to be cut by a clear or to stall
        job_cnt[j] = 4;
      end
      words += int'(job_len[j]) * int'(job_cnt[j]);
    end
    for (int d = 0; d < DELAY_N; d++) delay_tab[d] = $unsigned($random(seed)) % 6;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    next_cycle();
    check_flag(stream_valid_o, 1'b0, "stream_valid_o after reset");
    check_flag(done_o, 1'b0, "done_o after reset");
    check_flag(ready_start_o, 1'b1, "ready_start_o after reset");
    preload_bank();
    watch_cycles = words * 8 + 1000;

    // back to back random jobs
    for (int j = 0; j < NUM_JOBS; j++) begin
      start_job(j);
      wait_done();
    end

    // clear in the middle of a job
    start_job(NUM_JOBS);
    repeat (6) next_cycle();
    clear_i       = 1'b1;
    flush_pending = 1'b1;
    next_cycle();
    clear_i    = 1'b0;
    ready_seen = ready_start_o;
    next_cycle();
    ready_seen = ready_seen | ready_start_o;
    check_flag(ready_seen, 1'b1, "ready_start_o within two cycles of clear");
    next_cycle(); // any later beat finds no data owed

    // credits withheld, exactly a full credit window may arrive
    hold_credits = 1'b1;
    start_job(NUM_JOBS + 1);
    repeat (20) next_cycle();
    snap = beats;
    repeat (20) next_cycle();
    check_flag(beats == snap, 1'b1, "no beat while credits are withheld");
    check_flag(outstanding == `SRC_CREDITS, 1'b1, "beats sent up to the credit limit");
    hold_credits = 1'b0;
    wait_done();
    repeat (10) next_cycle();

    if (done_count == NUM_JOBS + 1 && exp_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Error at %0t: %0d done pulses and %0d beats owed, expected %0d and 0",
               $time, done_count, exp_q.size(), NUM_JOBS + 1);
      $display("Verification failed");
      $fatal(1, "done pulse count does not match finished jobs");
    end
  end

endmodule

// ==== stream_source_top.f ====
+incdir+logic
logic/stream_source_pkg.sv
logic/addr_fifo.sv
logic/stream_addrgen.sv
logic/stream_source.sv
logic/tcdm_bank.sv
logic/stream_source_top.sv
tests/tb_stream_source.sv

// ==== Makefile ====
TOP := tb_stream_source

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): stream_source_top.f logic/*.sv logic/*.svh tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f stream_source_top.f

# exit status is non-zero when the testbench stops with $fatal
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
